// ==== src/wrsp_bank_pkg.sv ====
package wrsp_bank_pkg;

  // Message width, identifier field included
  localparam int MsgWidth = 32;

  // Transaction identifier carried in the low bits of a message
  localparam int IdWidth = 4;
  localparam int NumIds = 2 ** IdWidth;

  // Shared slot pool
  localparam int Capacity = 64;
  localparam int AddrWidth = $clog2(Capacity);

  // One message as stored in the bank
  typedef logic [MsgWidth-1:0] msg_t;

  // Identifier taken from the low bits of a message
  typedef logic [IdWidth-1:0] id_t;

  // Address of one slot in the pool
  typedef logic [AddrWidth-1:0] slot_addr_t;

  // One bit per slot
  typedef logic [Capacity-1:0] slot_mask_t;

  // Per-identifier slot count, one bit wider so a full pool fits
  typedef logic [AddrWidth:0] count_t;

endpackage

// ==== src/slot_alloc_if.sv ====
`timescale 1ns/1ps

interface slot_alloc_if import wrsp_bank_pkg::*; ();

  // Reservation handshake and the slot it takes
  logic       take;
  slot_addr_t take_addr;

  // Slot handed back once its message has left
  logic       give_back;
  slot_addr_t give_back_addr;

  modport allocator (output take_addr, input take, input give_back, input give_back_addr);

  modport taker (output take, input take_addr);

  modport returner (output give_back, output give_back_addr);

endinterface

// ==== src/msg_ram_if.sv ====
`timescale 1ns/1ps

interface msg_ram_if import wrsp_bank_pkg::*; ();

  // Write port, driven by the fill side
  logic       wr_en;
  slot_addr_t wr_addr;
  msg_t       wr_data;

  // Read port, request from the list controller and data to the output stage
  logic       rd_en;
  slot_addr_t rd_addr;
  msg_t       rd_data;

  modport ram (input wr_en, wr_addr, wr_data, rd_en, rd_addr, output rd_data);

  modport writer (output wr_en, wr_addr, wr_data, rd_en, rd_addr);

  modport reader (input rd_en, rd_addr, rd_data);

endinterface

// ==== src/wrsp_slot_allocator.sv ====
`timescale 1ns/1ps

module wrsp_slot_allocator import wrsp_bank_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,

  slot_alloc_if.allocator alloc,

  output logic       res_valid_o,
  output slot_mask_t address_released_onehot_o
);

  slot_mask_t occ_q;
  slot_mask_t occ_d;
  slot_addr_t free_addr;

  // Lowest free slot, scanning down so the last hit wins
  always_comb begin
    free_addr = '0;
    for (int i = Capacity - 1; i >= 0; i--) begin
      if (!occ_q[i]) begin
        free_addr = slot_addr_t'(i);
      end
    end
  end

  assign alloc.take_addr = free_addr;
  assign res_valid_o     = ~&occ_q;

  // A taken slot is always free and a returned one always occupied,
  // so both updates never hit the same bit
  always_comb begin
    occ_d = occ_q;
    if (alloc.take) begin
      occ_d[alloc.take_addr] = 1'b1;
    end
    if (alloc.give_back) begin
      occ_d[alloc.give_back_addr] = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      occ_q <= '0;
    end else begin
      occ_q <= occ_d;
    end
  end

  // Report the returned slot in the same cycle it is accepted
  always_comb begin
    address_released_onehot_o = '0;
    if (alloc.give_back) begin
      address_released_onehot_o[alloc.give_back_addr] = 1'b1;
    end
  end

endmodule

// ==== src/wrsp_list_ctrl.sv ====
`timescale 1ns/1ps

module wrsp_list_ctrl import wrsp_bank_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,

  // Reservation side
  input  logic       res_ready_i,
  input  logic       res_valid_i,
  input  id_t        res_id_i,

  // Input message side
  input  msg_t       data_i,
  input  logic       in_valid_i,
  output logic       in_ready_o,

  // Release side
  input  slot_mask_t release_en_i,
  input  logic       accept_i,

  slot_alloc_if.taker alloc,
  msg_ram_if.writer   ram
);

  // Views of the per-identifier state, gathered for indexed access
  slot_addr_t       head_a [NumIds];
  slot_addr_t       fill_a [NumIds];
  slot_addr_t       tail_a [NumIds];
  logic [NumIds-1:0] listed;
  logic [NumIds-1:0] unfilled_nz;
  logic [NumIds-1:0] eligible;

  // Successor of each slot within its list
  slot_addr_t next_q [Capacity];

  id_t  in_id;
  id_t  sel_id;
  logic sel_valid;
  logic take;
  logic wr_en;
  logic rd_en;

  assign in_id = data_i[IdWidth-1:0];

  assign take       = res_valid_i && res_ready_i;
  assign alloc.take = take;

  // Input is taken only while its identifier still has a reserved slot
  assign in_ready_o  = in_valid_i && unfilled_nz[in_id];
  assign wr_en       = in_ready_o;
  assign ram.wr_en   = wr_en;
  assign ram.wr_addr = fill_a[in_id];
  assign ram.wr_data = data_i;

  // Lowest eligible identifier
  always_comb begin
    sel_valid = 1'b0;
    sel_id    = '0;
    for (int i = NumIds - 1; i >= 0; i--) begin
      if (eligible[i]) begin
        sel_valid = 1'b1;
        sel_id    = id_t'(i);
      end
    end
  end

  assign rd_en       = sel_valid && accept_i;
  assign ram.rd_en   = rd_en;
  assign ram.rd_addr = head_a[sel_id];

  // Link a new slot behind the current tail of a non-empty list
  always_ff @(posedge clk_i) begin
    if (take && listed[res_id_i]) begin
      next_q[tail_a[res_id_i]] <= alloc.take_addr;
    end
  end

  for (genvar g = 0; g < NumIds; g++) begin : g_id
    slot_addr_t head_q;
    slot_addr_t fill_q;
    slot_addr_t tail_q;
    count_t     unfilled_q;
    count_t     filled_q;
    count_t     total;
    logic       do_res;
    logic       do_fill;
    logic       do_rel;

    assign do_res  = take && (res_id_i == id_t'(g));
    assign do_fill = wr_en && (in_id == id_t'(g));
    assign do_rel  = rd_en && (sel_id == id_t'(g));
    assign total   = unfilled_q + filled_q;

    assign head_a[g]      = head_q;
    assign fill_a[g]      = fill_q;
    assign tail_a[g]      = tail_q;
    assign listed[g]      = (total != '0);
    assign unfilled_nz[g] = (unfilled_q != '0);
    assign eligible[g]    = (filled_q != '0) && release_en_i[head_q];

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        head_q     <= '0;
        fill_q     <= '0;
        tail_q     <= '0;
        unfilled_q <= '0;
        filled_q   <= '0;
      end else begin
        if (do_res) begin
          tail_q <= alloc.take_addr;
        end

        // The link to the new slot is written this cycle, so take it directly
        if (do_res && total == '0) begin
          head_q <= alloc.take_addr;
        end else if (do_rel) begin
          head_q <= (do_res && total == count_t'(1)) ? alloc.take_addr : next_q[head_q];
        end

        if (do_res && (unfilled_q == '0 || (do_fill && unfilled_q == count_t'(1)))) begin
          fill_q <= alloc.take_addr;
        end else if (do_fill) begin
          fill_q <= next_q[fill_q];
        end

        unfilled_q <= unfilled_q + count_t'(do_res) - count_t'(do_fill);
        filled_q   <= filled_q + count_t'(do_fill) - count_t'(do_rel);
      end
    end
  end

endmodule

// ==== src/wrsp_msg_ram.sv ====
`timescale 1ns/1ps

module wrsp_msg_ram import wrsp_bank_pkg::*; (
  input logic clk_i,

  msg_ram_if.ram ram
);

  msg_t mem_q [Capacity];
  msg_t rd_data_q;

  // Write port, lands at the input handshake edge
  always_ff @(posedge clk_i) begin
    if (ram.wr_en) begin
      mem_q[ram.wr_addr] <= ram.wr_data;
    end
  end

  // Read port with one cycle of latency; data holds between reads
  always_ff @(posedge clk_i) begin
    if (ram.rd_en) begin
      rd_data_q <= mem_q[ram.rd_addr];
    end
  end

  assign ram.rd_data = rd_data_q;

endmodule

// ==== src/wrsp_out_stage.sv ====
`timescale 1ns/1ps

module wrsp_out_stage import wrsp_bank_pkg::*; (
  input  logic clk_i,
  input  logic rst_ni,

  msg_ram_if.reader ram,

  input  logic out_ready_i,
  output logic out_valid_o,
  output msg_t data_o,
  output logic accept_o,

  slot_alloc_if.returner alloc
);

  logic       rd_pend_q;
  slot_addr_t rd_slot_q;
  logic       hold_valid_q;
  msg_t       hold_data_q;
  slot_addr_t hold_slot_q;
  logic       taken;

  // Fresh RAM data in the cycle after a read, else the held copy
  assign out_valid_o = rd_pend_q || hold_valid_q;
  assign data_o      = hold_valid_q ? hold_data_q : ram.rd_data;
  assign taken       = out_valid_o && out_ready_i;
  assign accept_o    = !out_valid_o || out_ready_i;

  assign alloc.give_back      = taken;
  assign alloc.give_back_addr = hold_valid_q ? hold_slot_q : rd_slot_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_pend_q    <= 1'b0;
      hold_valid_q <= 1'b0;
    end else begin
      rd_pend_q    <= ram.rd_en;
      hold_valid_q <= out_valid_o && !out_ready_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ram.rd_en) begin
      rd_slot_q <= ram.rd_addr;
    end
    // Capture fresh data that was not taken
    if (rd_pend_q && !out_ready_i) begin
      hold_data_q <= ram.rd_data;
      hold_slot_q <= rd_slot_q;
    end
  end

endmodule

// ==== src/wrsp_bank_top.sv ====
`timescale 1ns/1ps

module wrsp_bank_top import wrsp_bank_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,

  // Reservation
  input  id_t        reservation_request_id_i,
  output slot_addr_t new_reserved_address_o,
  input  logic       reservation_request_ready_i,
  output logic       reservation_request_valid_o,

  // Message data
  input  msg_t       data_i,
  output msg_t       data_o,

  // Release control and report
  input  slot_mask_t release_en_i,
  output slot_mask_t address_released_onehot_o,

  // Input and output handshakes
  input  logic       in_valid_i,
  output logic       in_ready_o,
  input  logic       out_ready_i,
  output logic       out_valid_o
);

  slot_alloc_if alloc_bus ();
  msg_ram_if    ram_bus ();

  logic accept;

  assign new_reserved_address_o = alloc_bus.take_addr;

  wrsp_slot_allocator u_slot_allocator (
    .clk_i                     (clk_i),
    .rst_ni                    (rst_ni),
    .alloc                     (alloc_bus),
    .res_valid_o               (reservation_request_valid_o),
    .address_released_onehot_o (address_released_onehot_o)
  );

  wrsp_list_ctrl u_list_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .res_ready_i  (reservation_request_ready_i),
    .res_valid_i  (reservation_request_valid_o),
    .res_id_i     (reservation_request_id_i),
    .data_i       (data_i),
    .in_valid_i   (in_valid_i),
    .in_ready_o   (in_ready_o),
    .release_en_i (release_en_i),
    .accept_i     (accept),
    .alloc        (alloc_bus),
    .ram          (ram_bus)
  );

  wrsp_msg_ram u_msg_ram (
    .clk_i (clk_i),
    .ram   (ram_bus)
  );

  wrsp_out_stage u_out_stage (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .ram         (ram_bus),
    .out_ready_i (out_ready_i),
    .out_valid_o (out_valid_o),
    .data_o      (data_o),
    .accept_o    (accept),
    .alloc       (alloc_bus)
  );

endmodule

// ==== verification/tb_wrsp_bank.sv ====
`timescale 1ns/1ps

module tb_wrsp_bank import wrsp_bank_pkg::*; ();

  // Tests run a few hundred cycles in total, so this bound is generous
  localparam int TimeoutCycles = 4000;

  logic       clk_i;
  logic       rst_ni;
  id_t        reservation_request_id_i;
  slot_addr_t new_reserved_address_o;
  logic       reservation_request_ready_i;
  logic       reservation_request_valid_o;
  msg_t       data_i;
  msg_t       data_o;
  slot_mask_t release_en_i;
  slot_mask_t address_released_onehot_o;
  logic       in_valid_i;
  logic       in_ready_o;
  logic       out_ready_i;
  logic       out_valid_o;

  // Reference model of the bank
  slot_mask_t occ_model;
  slot_addr_t unfilled_q [NumIds][$];
  slot_addr_t filled_q [NumIds][$];
  msg_t       mem_exp [Capacity];

  string test_name = "reset";
  int    cycle_cnt = 0;

  wrsp_bank_top u_dut (
    .clk_i                       (clk_i),
    .rst_ni                      (rst_ni),
    .reservation_request_id_i    (reservation_request_id_i),
    .new_reserved_address_o      (new_reserved_address_o),
    .reservation_request_ready_i (reservation_request_ready_i),
    .reservation_request_valid_o (reservation_request_valid_o),
    .data_i                      (data_i),
    .data_o                      (data_o),
    .release_en_i                (release_en_i),
    .address_released_onehot_o   (address_released_onehot_o),
    .in_valid_i                  (in_valid_i),
    .in_ready_o                  (in_ready_o),
    .out_ready_i                 (out_ready_i),
    .out_valid_o                 (out_valid_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  task automatic fail_run(string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "stopping at first error");
  endtask

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt > TimeoutCycles) begin
      fail_run($sformatf("run timed out after %0d cycles in test %s", cycle_cnt, test_name));
    end
  end

  task automatic check_msg(string what, msg_t exp, msg_t act);
    if (act !== exp) begin
      fail_run($sformatf("error %s %s: expected %h, actual %h", test_name, what, exp, act));
    end
  endtask

  task automatic check_addr(string what, slot_addr_t exp, slot_addr_t act);
    if (act !== exp) begin
      fail_run($sformatf("error %s %s: expected %0d, actual %0d", test_name, what, exp, act));
    end
  endtask

  task automatic check_mask(string what, slot_mask_t exp, slot_mask_t act);
    if (act !== exp) begin
      fail_run($sformatf("error %s %s: expected %h, actual %h", test_name, what, exp, act));
    end
  endtask

  task automatic check_bit(string what, logic exp, logic act);
    if (act !== exp) begin
      fail_run($sformatf("error %s %s: expected %b, actual %b", test_name, what, exp, act));
    end
  endtask

  // Drive point, shortly after the rising edge
  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  function automatic slot_addr_t lowest_free();
    for (int i = 0; i < Capacity; i++) begin
      if (!occ_model[i]) begin
        return slot_addr_t'(i);
      end
    end
    return '0;
  endfunction

  function automatic msg_t random_msg(id_t id);
    msg_t msg;
    msg = msg_t'($urandom());
    msg[IdWidth-1:0] = id;
    return msg;
  endfunction

  task automatic reserve(id_t id);
    slot_addr_t exp_addr;
    exp_addr = lowest_free();
    reservation_request_id_i    = id;
    reservation_request_ready_i = 1'b1;
    #1;
    check_bit("reservation_request_valid_o", 1'b1, reservation_request_valid_o);
    check_addr("new_reserved_address_o", exp_addr, new_reserved_address_o);
    occ_model[exp_addr] = 1'b1;
    unfilled_q[id].push_back(exp_addr);
    next_cycle();
    reservation_request_ready_i = 1'b0;
  endtask

  task automatic fill(id_t id);
    msg_t       msg;
    slot_addr_t addr;
    msg        = random_msg(id);
    data_i     = msg;
    in_valid_i = 1'b1;
    #1;
    check_bit("in_ready_o", 1'b1, in_ready_o);
    addr          = unfilled_q[id].pop_front();
    mem_exp[addr] = msg;
    filled_q[id].push_back(addr);
    next_cycle();
    in_valid_i = 1'b0;
  endtask

  // Offer a message that has no reserved slot; it must be refused
  task automatic refuse_input(id_t id);
    data_i     = random_msg(id);
    in_valid_i = 1'b1;
    #1;
    check_bit("in_ready_o", 1'b0, in_ready_o);
    in_valid_i = 1'b0;
    next_cycle();
  endtask

  // Take the oldest filled message of an identifier at the output
  task automatic expect_output(id_t id);
    slot_addr_t addr;
    addr        = filled_q[id].pop_front();
    out_ready_i = 1'b1;
    #1;
    while (!out_valid_o) begin
      next_cycle();
      #1;
    end
    check_msg("data_o", mem_exp[addr], data_o);
    check_mask("address_released_onehot_o", slot_mask_t'(1) << addr, address_released_onehot_o);
    occ_model[addr] = 1'b0;
    next_cycle();
  endtask

  task automatic test_reset_reserve();
    test_name = "reset_reserve";
    #1;
    check_bit("out_valid_o", 1'b0, out_valid_o);
    check_bit("in_ready_o", 1'b0, in_ready_o);
    check_mask("address_released_onehot_o", '0, address_released_onehot_o);
    check_bit("reservation_request_valid_o", 1'b1, reservation_request_valid_o);
    next_cycle();
    repeat (3) reserve(4'd3);
  endtask

  task automatic test_input_gating();
    test_name = "input_gating";
    refuse_input(4'd7);
    repeat (3) fill(4'd3);
    refuse_input(4'd3);
    release_en_i = '1;
    repeat (3) expect_output(4'd3);
    release_en_i = '0;
  endtask

  task automatic test_id_order();
    test_name = "id_order";
    repeat (3) reserve(4'd5);
    repeat (3) fill(4'd5);
    release_en_i = '1;
    repeat (3) expect_output(4'd5);
    release_en_i = '0;
  endtask

  task automatic test_release_priority();
    slot_mask_t en;
    test_name    = "release_priority";
    release_en_i = '0;
    out_ready_i  = 1'b1;
    reserve(4'd9);
    reserve(4'd2);
    fill(4'd9);
    fill(4'd2);
    repeat (20) begin
      check_bit("out_valid_o", 1'b0, out_valid_o);
      next_cycle();
    end
    en = (slot_mask_t'(1) << filled_q[9][0]) | (slot_mask_t'(1) << filled_q[2][0]);
    release_en_i = en;
    // Lower identifier must leave first
    expect_output(4'd2);
    expect_output(4'd9);
    release_en_i = '0;
  endtask

  task automatic test_back_pressure();
    slot_addr_t addr;
    test_name   = "back_pressure";
    out_ready_i = 1'b0;
    reserve(4'd4);
    reserve(4'd4);
    fill(4'd4);
    fill(4'd4);
    release_en_i = '1;
    // Output valid and data come from registers, stable at the drive point
    while (!out_valid_o) begin
      next_cycle();
    end
    addr = filled_q[4][0];
    repeat (10) begin
      #1;
      check_bit("out_valid_o", 1'b1, out_valid_o);
      check_msg("data_o", mem_exp[addr], data_o);
      check_mask("address_released_onehot_o", '0, address_released_onehot_o);
      next_cycle();
    end
    expect_output(4'd4);
    expect_output(4'd4);
    release_en_i = '0;
  endtask

  task automatic test_recycle_full();
    slot_addr_t addr;
    test_name    = "recycle_full";
    release_en_i = '0;
    out_ready_i  = 1'b1;
    for (int i = 0; i < Capacity; i++) begin
      reserve(id_t'(i % NumIds));
    end
    #1;
    check_bit("reservation_request_valid_o", 1'b0, reservation_request_valid_o);
    next_cycle();
    fill(4'd6);
    addr         = filled_q[6][0];
    release_en_i = slot_mask_t'(1) << addr;
    expect_output(4'd6);
    #1;
    check_bit("reservation_request_valid_o", 1'b1, reservation_request_valid_o);
    check_addr("new_reserved_address_o", addr, new_reserved_address_o);
    next_cycle();
  endtask

  initial begin
    void'($urandom(32'h9e73));
    rst_ni                      = 1'b0;
    reservation_request_id_i    = '0;
    reservation_request_ready_i = 1'b0;
    data_i                      = '0;
    release_en_i                = '0;
    in_valid_i                  = 1'b0;
    out_ready_i                 = 1'b1;
    occ_model                   = '0;
    repeat (2) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    test_reset_reserve();
    test_input_gating();
    test_id_order();
    test_release_priority();
    test_back_pressure();
    test_recycle_full();
    $display("RESULT: PASS");
    $finish;
  end

endmodule

// ==== wrsp_bank_top.f ====
src/wrsp_bank_pkg.sv
src/slot_alloc_if.sv
src/msg_ram_if.sv
src/wrsp_slot_allocator.sv
src/wrsp_list_ctrl.sv
src/wrsp_msg_ram.sv
src/wrsp_out_stage.sv
src/wrsp_bank_top.sv
verification/tb_wrsp_bank.sv

// ==== Makefile ====
TB_TOP := tb_wrsp_bank
OBJ    := obj_dir

.PHONY: all run lint clean

all: run

run: $(OBJ)/V$(TB_TOP)
	./$(OBJ)/V$(TB_TOP)

$(OBJ)/V$(TB_TOP): wrsp_bank_top.f $(wildcard src/*.sv) verification/tb_wrsp_bank.sv
	verilator --binary --timing -j 0 --top-module $(TB_TOP) -Mdir $(OBJ) -f wrsp_bank_top.f

lint:
	verilator --lint-only -Wall --timing --top-module wrsp_bank_top -f wrsp_bank_top.f

clean:
	rm -rf $(OBJ)
